/* Makefile */
VERILATOR  ?= verilator
TOP        ?= valu_tb
LINT_TOP   ?= valu_top
FILELIST   ?= files.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@grep -q "RESULT: PASS" $(LOG) || (echo "no pass line in $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(LINT_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* dv/valu_tb.sv */
`include "valu_consts.svh"

module valu_tb
  import valu_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int CYCLES_PER_OP = 50;

  logic        clk = 1'b0;
  logic        rst_n;
  logic        issue_valid;
  alu_uop_t    issue_uop;
  logic        iq_full;
  logic        result_valid;
  alu_result_t result;
  logic        result_ready;

  // 0 always ready, 1 random, 2 held low
  int          ready_mode = 0;
  alu_result_t exp_q[$];
  int          n_issued = 0;
  int          n_accepted = 0;
  logic [`VALU_ROB_W-1:0] next_tag = '0;
  logic        was_waiting = 1'b0;
  alu_result_t held;

  valu_top UUT (
    .clk          (clk),
    .rst_n        (rst_n),
    .issue_valid  (issue_valid),
    .issue_uop    (issue_uop),
    .iq_full      (iq_full),
    .result_valid (result_valid),
    .result       (result),
    .result_ready (result_ready)
  );

  always #10 clk = ~clk;

  task automatic stop_run(string why);
    $display("%s", why);
    $display("RESULT: FAIL");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check(string name, logic [71:0] got, logic [71:0] want);
    if (got !== want) begin
      stop_run($sformatf("Mismatch at time %0t: %s got 0x%0h expected 0x%0h",
                         $time, name, got, want));
    end
  endtask

  function automatic logic [`VALU_DATA_W-1:0] rnd64();
    return {$urandom, $urandom};
  endfunction

  // reference model, element by element
  function automatic alu_result_t expect_result(alu_uop_t u);
    alu_result_t             r;
    int                      w;
    int                      amt;
    logic [`VALU_DATA_W-1:0] m;
    logic [`VALU_DATA_W-1:0] a;
    logic [`VALU_DATA_W-1:0] b;
    logic [`VALU_DATA_W-1:0] e;
    logic [`VALU_DATA_W:0]   s;
    r.rob_entry = u.rob_entry;
    r.w_data    = '0;
    r.vsaturate = 1'b0;
    w = 8 << int'(u.eew);
    m = (w == `VALU_DATA_W) ? '1 : (64'd1 << w) - 64'd1;
    case (u.opcode)
      OP_MAND: r.w_data = u.vs2 & u.vs1;
      OP_MOR:  r.w_data = u.vs2 | u.vs1;
      OP_MXOR: r.w_data = u.vs2 ^ u.vs1;
      OP_CPOP: r.w_data = `VALU_DATA_W'($countones(u.vs2 & u.vs1));
      default: begin
        for (int i = 0; i < `VALU_DATA_W / w; i++) begin
          a   = (u.vs2 >> (i * w)) & m;
          b   = (u.vs1 >> (i * w)) & m;
          amt = int'(b[31:0]) & (w - 1);
          case (u.opcode)
            OP_ADD: e = (a + b) & m;
            OP_SUB: e = (a - b) & m;
            OP_SADDU: begin
              s = {1'b0, a} + {1'b0, b};
              if (s > {1'b0, m}) begin
                e = m;
                r.vsaturate = 1'b1;
              end else begin
                e = s[`VALU_DATA_W-1:0];
              end
            end
            OP_SLL: e = (a << amt) & m;
            OP_SRL: e = a >> amt;
            default: begin
              e = a >> amt;
              // sign fill of the vacated top bits
              if (a[w-1]) e = e | (m & ~(m >> amt));
            end
          endcase
          r.w_data = r.w_data | (e << (i * w));
        end
      end
    endcase
    return r;
  endfunction

  // at most one strobe every other cycle, so iq_full seen at the negedge is current
  task automatic issue(alu_opcode_e op, eew_e eew, logic [`VALU_DATA_W-1:0] vs2,
                       logic [`VALU_DATA_W-1:0] vs1);
    alu_uop_t u;
    u.rob_entry = next_tag;
    u.opcode    = op;
    u.eew       = eew;
    u.vs1       = vs1;
    u.vs2       = vs2;
    @(negedge clk);
    while (iq_full) @(negedge clk);
    @(posedge clk);
    issue_valid <= 1'b1;
    issue_uop   <= u;
    exp_q.push_back(expect_result(u));
    @(posedge clk);
    issue_valid <= 1'b0;
    next_tag++;
    n_issued++;
  endtask

  task automatic wait_drain();
    while (exp_q.size() != 0) @(negedge clk);
    @(posedge clk);
  endtask

  task automatic test_reset_idle();
    repeat (6) begin
      @(negedge clk);
      check("result_valid", result_valid, 0);
      check("iq_full", iq_full, 0);
    end
  endtask

  task automatic test_addsub();
    for (int e = 0; e < 4; e++) begin
      issue(OP_ADD, eew_e'(e), rnd64(), rnd64());
      issue(OP_ADD, eew_e'(e), '1, 64'h0101_0101_0101_0101);
      issue(OP_SUB, eew_e'(e), rnd64(), rnd64());
      issue(OP_SUB, eew_e'(e), '0, 64'h0101_0101_0101_0101);
      issue(OP_SADDU, eew_e'(e), 64'hf0f0_f0f0_f0f0_f0f0, 64'h2020_2020_2020_2020);
      issue(OP_SADDU, eew_e'(e), 64'h0101_0101_0101_0101, 64'h0202_0202_0202_0202);
      issue(OP_SADDU, eew_e'(e), rnd64(), rnd64());
    end
    wait_drain();
  endtask

  task automatic test_shift();
    for (int e = 0; e < 4; e++) begin
      issue(OP_SLL, eew_e'(e), rnd64(), rnd64());
      issue(OP_SRL, eew_e'(e), rnd64(), rnd64());
      issue(OP_SRA, eew_e'(e), rnd64(), rnd64());
      // every element negative at every width
      issue(OP_SRA, eew_e'(e), 64'h8421_8421_8421_8421 | 64'h8080_8080_8080_8080, rnd64());
    end
    wait_drain();
  endtask

  task automatic test_mask();
    issue(OP_MAND, EEW64, rnd64(), rnd64());
    issue(OP_MOR, EEW8, rnd64(), rnd64());
    issue(OP_MXOR, EEW32, rnd64(), rnd64());
    issue(OP_CPOP, EEW64, '1, '1);
    // result port held so cpops and single-cycle ops stack up behind stage 1
    ready_mode = 2;
    issue(OP_CPOP, EEW8, rnd64(), rnd64());
    issue(OP_ADD, EEW32, rnd64(), rnd64());
    issue(OP_CPOP, EEW16, rnd64(), rnd64());
    issue(OP_CPOP, EEW64, rnd64(), '1);
    ready_mode = 0;
    issue(OP_SLL, EEW16, rnd64(), rnd64());
    issue(OP_MXOR, EEW8, rnd64(), rnd64());
    wait_drain();
  endtask

  task automatic test_random_ready();
    ready_mode = 1;
    repeat (24) begin
      issue(alu_opcode_e'($urandom_range(9, 0)), eew_e'($urandom_range(3, 0)),
            rnd64(), rnd64());
    end
    wait_drain();
    ready_mode = 0;
  endtask

  task automatic test_burst();
    ready_mode = 2;
    repeat (4) issue(OP_ADD, eew_e'($urandom_range(3, 0)), rnd64(), rnd64());
    @(negedge clk);
    check("iq_full", iq_full, 1);
    ready_mode = 1;
    repeat (4) issue(OP_SUB, eew_e'($urandom_range(3, 0)), rnd64(), rnd64());
    wait_drain();
    ready_mode = 0;
  endtask

  initial begin
    result_ready = 1'b0;
    forever begin
      @(posedge clk);
      case (ready_mode)
        0:       result_ready <= 1'b1;
        1:       result_ready <= 1'($urandom_range(1, 0));
        default: result_ready <= 1'b0;
      endcase
    end
  end

  // outputs are settled by the falling edge
  always @(negedge clk) begin
    alu_result_t want;
    if (rst_n) begin
      if (was_waiting) begin
        check("result_valid held", result_valid, 1);
        check("result held", result, held);
      end
      if (result_valid && result_ready) begin
        if (exp_q.size() == 0) begin
          stop_run("a result was accepted with no micro-op outstanding");
        end else begin
          want = exp_q.pop_front();
          check("result.rob_entry", result.rob_entry, want.rob_entry);
          check("result.w_data", result.w_data, want.w_data);
          check("result.vsaturate", result.vsaturate, want.vsaturate);
          n_accepted++;
        end
      end
      was_waiting = result_valid && !result_ready;
      held        = result;
    end
  end

  initial begin : watchdog
    int cyc;
    cyc = 0;
    forever begin
      @(posedge clk);
      cyc++;
      if (cyc > CYCLES_PER_OP * (n_issued + 2)) begin
        stop_run($sformatf("timeout after %0d cycles with %0d micro-ops issued",
                           cyc, n_issued));
      end
    end
  end

  initial begin
    void'($urandom(1));
    rst_n       = 1'b0;
    issue_valid = 1'b0;
    issue_uop   = '0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    test_reset_idle();
    test_addsub();
    test_shift();
    test_mask();
    test_random_ready();
    test_burst();
    repeat (4) @(posedge clk);
    if (exp_q.size() == 0 && n_accepted == n_issued) begin
      $display("RESULT: PASS");
      $finish;
    end else begin
      stop_run($sformatf("%0d issued but %0d accepted at end of run", n_issued, n_accepted));
    end
  end

endmodule

/* files.f */
+incdir+src
src/valu_pkg.sv
src/valu_issue_queue.sv
src/valu_addsub.sv
src/valu_shift.sv
src/valu_mask.sv
src/valu_popcnt_p1.sv
src/valu_unit.sv
src/valu_top.sv
dv/valu_tb.sv

/* src/valu_addsub.sv */
`include "valu_consts.svh"

module valu_addsub
  import valu_pkg::*;
(
  input  logic        uop_valid,
  input  alu_uop_t    uop,
  output logic        result_valid,
  output alu_result_t result
);

  logic [3:0][`VALU_DATA_W-1:0] elem_res;
  logic [3:0]                   elem_sat;

  assign result_valid = uop_valid &&
                        (uop.opcode inside {OP_ADD, OP_SUB, OP_SADDU});

  // one lane layout per element width, picked by eew below
  for (genvar g = 0; g < 4; g++) begin : g_eew
    localparam int W = 8 << g;
    localparam int N = `VALU_DATA_W / W;

    logic [`VALU_DATA_W-1:0] res;
    logic [N-1:0]            clamp;
    logic [W:0]              sum_e;

    always_comb begin
      res   = '0;
      clamp = '0;
      sum_e = '0;
      for (int e = 0; e < N; e++) begin
        if (uop.opcode == OP_SUB) begin
          sum_e = {1'b0, uop.vs2[e*W +: W]} - {1'b0, uop.vs1[e*W +: W]};
        end else begin
          sum_e = {1'b0, uop.vs2[e*W +: W]} + {1'b0, uop.vs1[e*W +: W]};
        end
        // carry out of an unsigned add means overflow
        clamp[e]       = (uop.opcode == OP_SADDU) && sum_e[W];
        res[e*W +: W]  = clamp[e] ? {W{1'b1}} : sum_e[W-1:0];
      end
    end

    assign elem_res[g] = res;
    assign elem_sat[g] = |clamp;
  end

  assign result.rob_entry = uop.rob_entry;
  assign result.w_data    = elem_res[uop.eew];
  assign result.vsaturate = elem_sat[uop.eew];

endmodule

/* src/valu_consts.svh */
`ifndef VALU_CONSTS_SVH
`define VALU_CONSTS_SVH

// operand and result width
`define VALU_DATA_W 64

// reorder buffer tag
`define VALU_ROB_W 4

// reservation queue entries
`define VALU_IQ_DEPTH 4

`endif

/* src/valu_issue_queue.sv */
`include "valu_consts.svh"

module valu_issue_queue
  import valu_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     issue_valid,
  input  alu_uop_t issue_uop,
  input  logic     pop,
  output logic     head_valid,
  output alu_uop_t head_uop,
  output logic     full
);

  localparam int DEPTH = `VALU_IQ_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);

  alu_uop_t         mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;
  logic             do_write;
  logic             do_read;

  assign head_valid = (count != '0);
  assign full       = (count == (PTR_W+1)'(DEPTH));
  assign head_uop   = mem[rd_ptr];

  // a strobe while full is dropped
  assign do_write = issue_valid && !full;
  assign do_read  = pop && head_valid;

  always_ff @(posedge clk) begin
    if (do_write) begin
      mem[wr_ptr] <= issue_uop;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_write) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH-1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_read) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH-1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_write, do_read})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

/* src/valu_mask.sv */
module valu_mask
  import valu_pkg::*;
(
  input  logic        uop_valid,
  input  alu_uop_t    uop,
  output logic        result_valid,
  output alu_result_t result,
  output pipe_data_t  partial,
  output logic        two_cycle
);

  logic [$bits(uop.vs2)-1:0] cpop_src;

  assign result_valid = uop_valid &&
                        (uop.opcode inside {OP_MAND, OP_MOR, OP_MXOR, OP_CPOP});
  assign two_cycle    = uop_valid && (uop.opcode == OP_CPOP);

  always_comb begin
    result.rob_entry = uop.rob_entry;
    result.vsaturate = 1'b0;
    case (uop.opcode)
      OP_MAND: result.w_data = uop.vs2 & uop.vs1;
      OP_MOR:  result.w_data = uop.vs2 | uop.vs1;
      default: result.w_data = uop.vs2 ^ uop.vs1;
    endcase
  end

  // first half of cpop, count each byte on its own
  assign cpop_src = uop.vs2 & uop.vs1;

  always_comb begin
    partial.rob_entry = uop.rob_entry;
    for (int i = 0; i < $bits(cpop_src) / 8; i++) begin
      partial.partial[i] = 4'($countones(cpop_src[i*8 +: 8]));
    end
  end

endmodule

/* src/valu_pkg.sv */
`include "valu_consts.svh"

package valu_pkg;

  typedef enum logic [3:0] {
    OP_ADD,
    OP_SUB,
    OP_SADDU,
    OP_SLL,
    OP_SRL,
    OP_SRA,
    OP_MAND,
    OP_MOR,
    OP_MXOR,
    OP_CPOP
  } alu_opcode_e;

  typedef enum logic [1:0] {
    EEW8,
    EEW16,
    EEW32,
    EEW64
  } eew_e;

  typedef struct packed {
    logic [`VALU_ROB_W-1:0]  rob_entry;
    alu_opcode_e             opcode;
    eew_e                    eew;
    logic [`VALU_DATA_W-1:0] vs1;
    logic [`VALU_DATA_W-1:0] vs2;
  } alu_uop_t;

  typedef struct packed {
    logic [`VALU_ROB_W-1:0]  rob_entry;
    logic [`VALU_DATA_W-1:0] w_data;
    logic                    vsaturate;
  } alu_result_t;

  // per-byte ones counts, one nibble per byte of the operand
  typedef struct packed {
    logic [`VALU_ROB_W-1:0]                rob_entry;
    logic [`VALU_DATA_W/8-1:0][3:0]        partial;
  } pipe_data_t;

endpackage

/* src/valu_popcnt_p1.sv */
`include "valu_consts.svh"

module valu_popcnt_p1
  import valu_pkg::*;
(
  input  pipe_data_t  stage_data,
  output alu_result_t result
);

  localparam int NB = `VALU_DATA_W / 8;

  logic [$clog2(`VALU_DATA_W):0] cnt;

  always_comb begin
    cnt = '0;
    for (int i = 0; i < NB; i++) begin
      cnt = cnt + stage_data.partial[i];
    end
  end

  assign result.rob_entry = stage_data.rob_entry;
  assign result.w_data    = `VALU_DATA_W'(cnt);
  assign result.vsaturate = 1'b0;

endmodule

/* src/valu_shift.sv */
`include "valu_consts.svh"

module valu_shift
  import valu_pkg::*;
(
  input  logic        uop_valid,
  input  alu_uop_t    uop,
  output logic        result_valid,
  output alu_result_t result
);

  logic [3:0][`VALU_DATA_W-1:0] elem_res;

  assign result_valid = uop_valid &&
                        (uop.opcode inside {OP_SLL, OP_SRL, OP_SRA});

  for (genvar g = 0; g < 4; g++) begin : g_eew
    localparam int W  = 8 << g;
    localparam int N  = `VALU_DATA_W / W;
    // amount is log2(W) bits of the vs1 element
    localparam int SW = 3 + g;

    logic [`VALU_DATA_W-1:0] res;

    always_comb begin
      res = '0;
      for (int e = 0; e < N; e++) begin
        case (uop.opcode)
          OP_SLL:  res[e*W +: W] = uop.vs2[e*W +: W] << uop.vs1[e*W +: SW];
          OP_SRL:  res[e*W +: W] = uop.vs2[e*W +: W] >> uop.vs1[e*W +: SW];
          default: res[e*W +: W] = $signed(uop.vs2[e*W +: W]) >>> uop.vs1[e*W +: SW];
        endcase
      end
    end

    assign elem_res[g] = res;
  end

  assign result.rob_entry = uop.rob_entry;
  assign result.w_data    = elem_res[uop.eew];
  assign result.vsaturate = 1'b0;

endmodule

/* src/valu_top.sv */
module valu_top
  import valu_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        issue_valid,
  input  alu_uop_t    issue_uop,
  output logic        iq_full,
  output logic        result_valid,
  output alu_result_t result,
  input  logic        result_ready
);

  logic     head_valid;
  alu_uop_t head_uop;
  logic     pop;

  valu_issue_queue u_issue_queue (
    .clk         (clk),
    .rst_n       (rst_n),
    .issue_valid (issue_valid),
    .issue_uop   (issue_uop),
    .pop         (pop),
    .head_valid  (head_valid),
    .head_uop    (head_uop),
    .full        (iq_full)
  );

  valu_unit u_unit (
    .clk          (clk),
    .rst_n        (rst_n),
    .uop_valid    (head_valid),
    .uop          (head_uop),
    .pop          (pop),
    .result_valid (result_valid),
    .result       (result),
    .result_ready (result_ready)
  );

endmodule

/* src/valu_unit.sv */
module valu_unit
  import valu_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        uop_valid,
  input  alu_uop_t    uop,
  output logic        pop,
  output logic        result_valid,
  output alu_result_t result,
  input  logic        result_ready
);

  logic        valid_addsub;
  alu_result_t res_addsub;
  logic        valid_shift;
  alu_result_t res_shift;
  logic        valid_mask;
  alu_result_t res_mask;
  pipe_data_t  mask_partial;
  logic        mask_two_cycle;
  logic        any_p0;

  // stage 1 holds a cpop between its two halves
  logic        s1_valid;
  logic        s1_load;
  pipe_data_t  s1_data;
  alu_result_t res_p1;

  valu_addsub u_addsub (
    .uop_valid    (uop_valid),
    .uop          (uop),
    .result_valid (valid_addsub),
    .result       (res_addsub)
  );

  valu_shift u_shift (
    .uop_valid    (uop_valid),
    .uop          (uop),
    .result_valid (valid_shift),
    .result       (res_shift)
  );

  valu_mask u_mask (
    .uop_valid    (uop_valid),
    .uop          (uop),
    .result_valid (valid_mask),
    .result       (res_mask),
    .partial      (mask_partial),
    .two_cycle    (mask_two_cycle)
  );

  valu_popcnt_p1 u_popcnt_p1 (
    .stage_data (s1_data),
    .result     (res_p1)
  );

  assign any_p0  = valid_addsub | valid_shift | valid_mask;
  assign s1_load = !s1_valid && mask_two_cycle;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid <= 1'b0;
    end else if (s1_load) begin
      s1_valid <= 1'b1;
    end else if (s1_valid && result_ready) begin
      s1_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (s1_load) begin
      s1_data <= mask_partial;
    end
  end

  // head stalls while stage 1 is busy so results stay in order
  assign result_valid = s1_valid || (any_p0 && !mask_two_cycle);
  assign pop          = !s1_valid && any_p0 && (mask_two_cycle || result_ready);

  always_comb begin
    if (s1_valid) begin
      result = res_p1;
    end else if (valid_addsub) begin
      result = res_addsub;
    end else if (valid_shift) begin
      result = res_shift;
    end else begin
      result = res_mask;
    end
  end

endmodule
